/* ttc_cfg.svh */
// build-time sizing for the timer counter; address fields assume the 4-bit word address adr[5:2]
`ifndef TTC_CFG_SVH
`define TTC_CFG_SVH

// ----------------------------------------
// sizing
// ----------------------------------------
// timer channels, at most 3 with a 2-bit channel field
`define TTC_NUM_CH 3
`define TTC_CNT_W 16
// prescaler counter, wide enough for exponent 15
`define TTC_PS_W 16
`define TTC_CLK_CTRL_W 7
`define TTC_ADR_W 4
`define TTC_DAT_W 32

// ----------------------------------------
// address fields in adr
// ----------------------------------------
`define TTC_CH_HI 3
`define TTC_CH_LO 2
`define TTC_REG_HI 1
`define TTC_REG_LO 0
// channel field value of the shared irq registers
`define TTC_SHARED_CH 2'd3
`define TTC_REG_CLK_CTRL 2'd0
`define TTC_REG_CNTR_CTRL 2'd1
`define TTC_REG_INTERVAL 2'd2
`define TTC_REG_COUNT 2'd3
`define TTC_REG_IRQ_STAT 2'd0
`define TTC_REG_IRQ_EN 2'd1
`endif

/* ttc_pkg.sv */
// shared types of the timer counter; widths follow ttc_cfg.svh, full-word wishbone only
`include "ttc_cfg.svh"

package ttc_pkg;

  // ----------------------------------------
  // plain vectors
  // ----------------------------------------
  // bit 0 prescale enable, bits 4:1 exponent, bits 6:5 reserved
  typedef logic [`TTC_CLK_CTRL_W-1:0] clk_ctrl_t;
  typedef logic [`TTC_CNT_W-1:0] cnt_t;
  typedef logic [`TTC_PS_W-1:0] ps_cnt_t;
  // one bit per channel
  typedef logic [`TTC_NUM_CH-1:0] ch_mask_t;
  typedef logic [`TTC_ADR_W-1:0] wb_adr_t;
  typedef logic [`TTC_DAT_W-1:0] wb_dat_t;
  typedef logic [`TTC_CH_HI-`TTC_CH_LO:0] ch_idx_t;
  typedef logic [`TTC_REG_HI-`TTC_REG_LO:0] reg_idx_t;

  // ----------------------------------------
  // bus and channel bundles
  // ----------------------------------------
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    wb_adr_t adr;
    wb_dat_t dat;
  } wb_req_t;

  // dat only valid with ack
  typedef struct packed {
    logic ack;
    wb_dat_t dat;
  } wb_rsp_t;

  typedef struct packed {
    logic clk_ctrl_wr;
    clk_ctrl_t clk_ctrl_data;
    logic disabled;
    logic interval_mode;
    logic restart;
    cnt_t interval;
  } ch_cfg_t;

  typedef struct packed {
    cnt_t count;
    clk_ctrl_t clk_ctrl;
    logic evt;
  } ch_stat_t;

  typedef enum logic [1:0] {ch_stopped, ch_restarting, ch_counting} ch_state_e;

endpackage

/* ttc_count_rst.sv */
// clock control register and restart edge logic; only the first restart cycle drops count_en
`timescale 1ns/100ps

module ttc_count_rst (
  input  logic                 pclk10,
  input  logic                 n_p_reset10,
  input  ttc_pkg::clk_ctrl_t   clk_ctrl_data,
  input  logic                 clk_ctrl_sel,
  input  logic                 restart,
  output logic                 count_en,
  output ttc_pkg::clk_ctrl_t   clk_ctrl
);

  // set while restart is held, so a long restart drops count_en once
  logic restart_seen;

  // ----------------------------------------
  // count enable
  // ----------------------------------------
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      restart_seen <= 1'b0;
      count_en <= 1'b0;
    end
    else if (restart && !restart_seen)
    begin
      restart_seen <= 1'b1;
      count_en <= 1'b0;
    end
    else
    begin
      restart_seen <= restart;
      count_en <= 1'b1;
    end
  end

  // clock control, loads on select and holds otherwise
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
      clk_ctrl <= '0;
    else if (clk_ctrl_sel)
      clk_ctrl <= clk_ctrl_data;
  end

endmodule

/* ttc_channel.sv */
// one timer channel: power-of-two prescaler and up counter, no external clock or match outputs
`timescale 1ns/100ps
`include "ttc_cfg.svh"

module ttc_channel (
  input  logic                pclk10,
  input  logic                n_p_reset10,
  input  ttc_pkg::ch_cfg_t    cfg,
  output ttc_pkg::ch_stat_t   stat
);

  logic count_en;
  ttc_pkg::clk_ctrl_t clk_ctrl;
  ttc_pkg::ch_state_e state;
  logic ps_en;
  logic [3:0] ps_exp;
  ttc_pkg::ps_cnt_t ps_cnt_q;
  ttc_pkg::ps_cnt_t ps_lim;
  logic tick;
  logic run;
  logic wrap_hit;
  ttc_pkg::cnt_t cnt_q;
  logic evt_q;

  ttc_count_rst u_count_rst (
    .pclk10        (pclk10),
    .n_p_reset10   (n_p_reset10),
    .clk_ctrl_data (cfg.clk_ctrl_data),
    .clk_ctrl_sel  (cfg.clk_ctrl_wr),
    .restart       (cfg.restart),
    .count_en      (count_en),
    .clk_ctrl      (clk_ctrl)
  );

  // ----------------------------------------
  // channel state
  // ----------------------------------------
  // restarting covers the restart pulse and the dead count_en cycle
  always_comb
  begin
    if (cfg.restart || !count_en)
      state = ttc_pkg::ch_restarting;
    else if (cfg.disabled)
      state = ttc_pkg::ch_stopped;
    else
      state = ttc_pkg::ch_counting;
  end

  assign run = (state == ttc_pkg::ch_counting);

  // ----------------------------------------
  // prescaler
  // ----------------------------------------
  // bits 6:5 of clk_ctrl are ignored here
  assign ps_en = clk_ctrl[0];
  assign ps_exp = clk_ctrl[4:1];
  // terminal count 2^(N+1)-1
  assign ps_lim = ~({`TTC_PS_W{1'b1}} << ({1'b0, ps_exp} + 5'd1));
  // >= so a smaller exponent written mid-count still ticks
  assign tick = !ps_en || (ps_cnt_q >= ps_lim);

  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
      ps_cnt_q <= '0;
    else if (cfg.restart || (run && tick))
      ps_cnt_q <= '0;
    else if (run)
      ps_cnt_q <= ps_cnt_q + 1'b1;
  end

  // ----------------------------------------
  // counter and wrap
  // ----------------------------------------
  // interval mode uses >= so a lowered interval still wraps
  assign wrap_hit = cfg.interval_mode ? (cnt_q >= cfg.interval) : (&cnt_q);

  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      cnt_q <= '0;
      evt_q <= 1'b0;
    end
    else
    begin
      evt_q <= 1'b0;
      if (cfg.restart)
        cnt_q <= '0;
      else if (run && tick)
      begin
        if (wrap_hit)
        begin
          cnt_q <= '0;
          evt_q <= 1'b1;
        end
        else
          cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign stat = '{count: cnt_q, clk_ctrl: clk_ctrl, evt: evt_q};

  // restart from the register block is always a single pulse
  a_restart_pulse: assert property (@(posedge pclk10) disable iff (!n_p_reset10)
    cfg.restart |=> !cfg.restart);

endmodule

/* ttc_wb_regs.sv */
// wishbone classic slave with one-cycle ack, no wait states, no err, full 32-bit words only
`timescale 1ns/100ps
`include "ttc_cfg.svh"

module ttc_wb_regs (
  input  logic               pclk10,
  input  logic               n_p_reset10,
  input  ttc_pkg::wb_req_t   wb_req,
  output ttc_pkg::wb_rsp_t   wb_rsp,
  output ttc_pkg::ch_cfg_t   ch_cfg [`TTC_NUM_CH],
  input  ttc_pkg::ch_stat_t  ch_stat [`TTC_NUM_CH],
  input  ttc_pkg::ch_mask_t  irq_status,
  output ttc_pkg::ch_mask_t  irq_enable,
  output logic               status_rd
);

  logic ack_q;
  ttc_pkg::wb_dat_t rdat_q;
  ttc_pkg::wb_dat_t rd_data;
  logic acc;
  logic wr_acc;
  logic rd_acc;
  ttc_pkg::ch_idx_t ch_sel;
  ttc_pkg::reg_idx_t reg_sel;
  ttc_pkg::ch_mask_t dis_q;
  ttc_pkg::ch_mask_t imode_q;
  ttc_pkg::ch_mask_t restart_q;
  ttc_pkg::ch_mask_t enable_q;
  ttc_pkg::cnt_t interval_q [`TTC_NUM_CH];

  // ----------------------------------------
  // decode
  // ----------------------------------------
  // new request only while no ack is out
  assign acc = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr_acc = acc && wb_req.we;
  assign rd_acc = acc && !wb_req.we;
  assign ch_sel = wb_req.adr[`TTC_CH_HI:`TTC_CH_LO];
  assign reg_sel = wb_req.adr[`TTC_REG_HI:`TTC_REG_LO];

  // clear happens on the ack edge, read data sampled before it
  assign status_rd = rd_acc && (ch_sel == `TTC_SHARED_CH) && (reg_sel == `TTC_REG_IRQ_STAT);

  // per-channel config, clk_ctrl write is a same-edge strobe
  always_comb
  begin
    for (int c = 0; c < `TTC_NUM_CH; c++)
    begin
      ch_cfg[c].clk_ctrl_wr = wr_acc && (ch_sel == ttc_pkg::ch_idx_t'(c)) &&
                              (reg_sel == `TTC_REG_CLK_CTRL);
      ch_cfg[c].clk_ctrl_data = wb_req.dat[`TTC_CLK_CTRL_W-1:0];
      ch_cfg[c].disabled = dis_q[c];
      ch_cfg[c].interval_mode = imode_q[c];
      ch_cfg[c].restart = restart_q[c];
      ch_cfg[c].interval = interval_q[c];
    end
  end

  // read mux, unmapped addresses give 0
  always_comb
  begin
    rd_data = '0;
    if (ch_sel == `TTC_SHARED_CH)
    begin
      if (reg_sel == `TTC_REG_IRQ_STAT)
        rd_data = ttc_pkg::wb_dat_t'(irq_status);
      else if (reg_sel == `TTC_REG_IRQ_EN)
        rd_data = ttc_pkg::wb_dat_t'(enable_q);
    end
    for (int c = 0; c < `TTC_NUM_CH; c++)
    begin
      if (ch_sel == ttc_pkg::ch_idx_t'(c))
      begin
        case (reg_sel)
          `TTC_REG_CLK_CTRL: rd_data = ttc_pkg::wb_dat_t'(ch_stat[c].clk_ctrl);
          // restart bit reads back as 0
          `TTC_REG_CNTR_CTRL: rd_data = ttc_pkg::wb_dat_t'({imode_q[c], dis_q[c]});
          `TTC_REG_INTERVAL: rd_data = ttc_pkg::wb_dat_t'(interval_q[c]);
          `TTC_REG_COUNT: rd_data = ttc_pkg::wb_dat_t'(ch_stat[c].count);
          default: rd_data = '0;
        endcase
      end
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      ack_q <= 1'b0;
      rdat_q <= '0;
      dis_q <= '0;
      imode_q <= '0;
      restart_q <= '0;
      enable_q <= '0;
      for (int c = 0; c < `TTC_NUM_CH; c++)
        interval_q[c] <= '0;
    end
    else
    begin
      ack_q <= acc;
      // restart lives one cycle only
      restart_q <= '0;
      if (rd_acc)
        rdat_q <= rd_data;
      if (wr_acc && (ch_sel == `TTC_SHARED_CH) && (reg_sel == `TTC_REG_IRQ_EN))
        enable_q <= wb_req.dat[`TTC_NUM_CH-1:0];
      for (int c = 0; c < `TTC_NUM_CH; c++)
      begin
        if (wr_acc && (ch_sel == ttc_pkg::ch_idx_t'(c)))
        begin
          if (reg_sel == `TTC_REG_CNTR_CTRL)
          begin
            // bit 0 disable, bit 1 interval mode, bit 2 restart
            dis_q[c] <= wb_req.dat[0];
            imode_q[c] <= wb_req.dat[1];
            restart_q[c] <= wb_req.dat[2];
          end
          else if (reg_sel == `TTC_REG_INTERVAL)
            interval_q[c] <= wb_req.dat[`TTC_CNT_W-1:0];
        end
      end
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: rdat_q};
  assign irq_enable = enable_q;

  // single-cycle ack even when the master keeps stb up
  a_ack_single: assert property (@(posedge pclk10) disable iff (!n_p_reset10)
    (wb_rsp.ack && wb_req.stb) |=> !wb_rsp.ack);

endmodule

/* ttc_irq_combine.sv */
// sticky per-channel status with clear-on-read; irq lags status by one registered stage
`timescale 1ns/100ps
`include "ttc_cfg.svh"

module ttc_irq_combine (
  input  logic                pclk10,
  input  logic                n_p_reset10,
  input  ttc_pkg::ch_mask_t   events,
  input  logic                status_rd,
  input  ttc_pkg::ch_mask_t   enable,
  output ttc_pkg::ch_mask_t   status,
  output logic                irq
);

  ttc_pkg::ch_mask_t status_q;
  ttc_pkg::ch_mask_t status_nxt;
  ttc_pkg::ch_mask_t clr_mask;
  logic irq_q;

  // ----------------------------------------
  // sticky status
  // ----------------------------------------
  // read clears all bits at once
  assign clr_mask = {`TTC_NUM_CH{status_rd}};

  // new event on the clear cycle survives
  assign status_nxt = (status_q & ~clr_mask) | events;

  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
      status_q <= '0;
    else
      status_q <= status_nxt;
  end

  // ----------------------------------------
  // interrupt line
  // ----------------------------------------
  // masked OR of the current status, one cycle behind it
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
      irq_q <= 1'b0;
    else
      irq_q <= |(status_q & enable);
  end

  assign status = status_q;
  assign irq = irq_q;

endmodule

/* ttc_top.sv */
// triple timer counter top; single clock domain, wishbone classic slave, one level irq output
`timescale 1ns/100ps
`include "ttc_cfg.svh"

module ttc_top (
  input  logic               pclk10,
  input  logic               n_p_reset10,
  input  ttc_pkg::wb_req_t   wb_req,
  output ttc_pkg::wb_rsp_t   wb_rsp,
  output logic               irq
);

  ttc_pkg::ch_cfg_t ch_cfg [`TTC_NUM_CH];
  ttc_pkg::ch_stat_t ch_stat [`TTC_NUM_CH];
  ttc_pkg::ch_mask_t events;
  ttc_pkg::ch_mask_t irq_status;
  ttc_pkg::ch_mask_t irq_enable;
  logic status_rd;

  // ----------------------------------------
  // register block
  // ----------------------------------------
  ttc_wb_regs u_regs (
    .pclk10      (pclk10),
    .n_p_reset10 (n_p_reset10),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .ch_cfg      (ch_cfg),
    .ch_stat     (ch_stat),
    .irq_status  (irq_status),
    .irq_enable  (irq_enable),
    .status_rd   (status_rd)
  );

  // identical channels, event bits gathered into one mask
  for (genvar c = 0; c < `TTC_NUM_CH; c++)
  begin : g_ch
    ttc_channel u_channel (
      .pclk10      (pclk10),
      .n_p_reset10 (n_p_reset10),
      .cfg         (ch_cfg[c]),
      .stat        (ch_stat[c])
    );
    assign events[c] = ch_stat[c].evt;
  end

  // interrupt status and line
  ttc_irq_combine u_irq (
    .pclk10      (pclk10),
    .n_p_reset10 (n_p_reset10),
    .events      (events),
    .status_rd   (status_rd),
    .enable      (irq_enable),
    .status      (irq_status),
    .irq         (irq)
  );

endmodule

/* tb_ttc_checker.sv */
// watches the wishbone bus and irq of ttc_top; assumes one request in flight at a time
`timescale 1ns/100ps

module tb_ttc_checker (
  input  logic              pclk10,
  input  logic              n_p_reset10,
  input  ttc_pkg::wb_req_t  wb_req,
  input  ttc_pkg::wb_rsp_t  wb_rsp,
  input  logic              irq,
  input  logic              exp_en,
  input  ttc_pkg::wb_dat_t  exp_lo,
  input  ttc_pkg::wb_dat_t  exp_hi,
  input  logic              irq_chk_en,
  input  logic              irq_exp,
  output int                err_cnt,
  output int                chk_cnt
);

  int wait_cnt;
  logic ack_prev;
  logic in_range;
  // request as seen on its first cycle
  logic req_we;
  logic req_chk;
  ttc_pkg::wb_adr_t req_adr;
  ttc_pkg::wb_dat_t req_lo;
  ttc_pkg::wb_dat_t req_hi;

  initial
  begin
    err_cnt = 0;
    chk_cnt = 0;
  end

  // ----------------------------------------
  // ack timing and read data
  // ----------------------------------------
  always @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      wait_cnt = 0;
      ack_prev = 1'b0;
    end
    else
    begin
      if (wb_rsp.ack)
      begin
        if (ack_prev)
        begin
          $display("ack stayed high for two cycles at time %0t", $time);
          err_cnt++;
        end
        else if (wait_cnt == 0)
        begin
          $display("ack came without a pending request at time %0t", $time);
          err_cnt++;
        end
        else if (wait_cnt != 1)
        begin
          $display("[FAIL] %0t ack after %0d cycles, expected 1", $time, wait_cnt);
          err_cnt++;
        end
        if (wait_cnt != 0 && !req_we && req_chk)
        begin
          chk_cnt++;
          in_range = (wb_rsp.dat >= req_lo) && (wb_rsp.dat <= req_hi);
          if (in_range !== 1'b1)
          begin
            $display("[FAIL] %0t read adr %0h got %0h, expected %0h..%0h",
                     $time, req_adr, wb_rsp.dat, req_lo, req_hi);
            err_cnt++;
          end
        end
        wait_cnt = 0;
      end
      else if (wb_req.cyc && wb_req.stb)
      begin
        if (wait_cnt == 0)
        begin
          req_we = wb_req.we;
          req_adr = wb_req.adr;
          req_chk = exp_en;
          req_lo = exp_lo;
          req_hi = exp_hi;
        end
        wait_cnt++;
        if (wait_cnt == 4)
        begin
          $display("no ack for the request to adr %0h at time %0t", req_adr, $time);
          err_cnt++;
        end
      end
      // irq line against the masked status of the model
      if (irq_chk_en)
      begin
        chk_cnt++;
        if (irq !== irq_exp)
        begin
          $display("[FAIL] %0t irq is %b, expected %b", $time, irq, irq_exp);
          err_cnt++;
        end
      end
      ack_prev = wb_rsp.ack;
    end
  end

endmodule

/* tb_ttc.sv */
// testbench for ttc_top; prescaled counts are only range checked, test intervals stay at 4 or more
`timescale 1ns/100ps
`include "ttc_cfg.svh"

module tb_ttc;

  // longest single wait is the irq wait, (40+1)*8+4 cycles
  localparam int N_TXN = 300;
  localparam int MAX_WAIT_CYC = 340;
  localparam int WD_NS = N_TXN * MAX_WAIT_CYC * 8 + 2000;
  localparam int N_RAND = 40;
  localparam int SHARED = 3;

  logic pclk10;
  logic n_p_reset10;
  ttc_pkg::wb_req_t wb_req;
  ttc_pkg::wb_rsp_t wb_rsp;
  logic irq;
  logic exp_en;
  ttc_pkg::wb_dat_t exp_lo;
  ttc_pkg::wb_dat_t exp_hi;
  logic irq_chk_en;
  logic irq_exp;
  int err_cnt;
  int chk_cnt;
  integer seed;
  // register model
  ttc_pkg::clk_ctrl_t m_clk [`TTC_NUM_CH];
  logic [1:0] m_ctrl [`TTC_NUM_CH];
  ttc_pkg::cnt_t m_iv [`TTC_NUM_CH];
  ttc_pkg::ch_mask_t m_en;

  ttc_top ttc_top_inst (
    .pclk10      (pclk10),
    .n_p_reset10 (n_p_reset10),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .irq         (irq)
  );

  tb_ttc_checker u_checker (
    .pclk10      (pclk10),
    .n_p_reset10 (n_p_reset10),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .irq         (irq),
    .exp_en      (exp_en),
    .exp_lo      (exp_lo),
    .exp_hi      (exp_hi),
    .irq_chk_en  (irq_chk_en),
    .irq_exp     (irq_exp),
    .err_cnt     (err_cnt),
    .chk_cnt     (chk_cnt)
  );

  initial
    pclk10 = 1'b0;
  always
    #4 pclk10 = ~pclk10;

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic int pick(input int lo, input int hi);
    pick = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic ttc_pkg::wb_adr_t reg_adr(input int ch, input int rg);
    ttc_pkg::wb_adr_t a;
    a = '0;
    a[`TTC_CH_HI:`TTC_CH_LO] = ttc_pkg::ch_idx_t'(ch);
    a[`TTC_REG_HI:`TTC_REG_LO] = ttc_pkg::reg_idx_t'(rg);
    return a;
  endfunction

  // mirror of the address map, writes to unmapped or read-only regs ignored
  function automatic void model_write(input int ch, input int rg, input ttc_pkg::wb_dat_t dat);
    if (ch == SHARED)
    begin
      if (rg == 1)
        m_en = dat[`TTC_NUM_CH-1:0];
    end
    else if (rg == 0)
      m_clk[ch] = dat[6:0];
    else if (rg == 1)
      m_ctrl[ch] = dat[1:0];
    else if (rg == 2)
      m_iv[ch] = dat[15:0];
  endfunction

  function automatic ttc_pkg::wb_dat_t model_read(input int ch, input int rg);
    model_read = '0;
    if (ch == SHARED && rg == 1)
      model_read = ttc_pkg::wb_dat_t'(m_en);
    else if (ch != SHARED && rg == 0)
      model_read = ttc_pkg::wb_dat_t'(m_clk[ch]);
    else if (ch != SHARED && rg == 1)
      model_read = ttc_pkg::wb_dat_t'(m_ctrl[ch]);
    else if (ch != SHARED && rg == 2)
      model_read = ttc_pkg::wb_dat_t'(m_iv[ch]);
  endfunction

  // one classic cycle, driven on the falling edge, held until ack
  task automatic bus_xfer(input logic we, input ttc_pkg::wb_adr_t adr,
                          input ttc_pkg::wb_dat_t wdat, output ttc_pkg::wb_dat_t rdat);
    int n;
    @(negedge pclk10);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    n = 0;
    do
    begin
      @(negedge pclk10);
      n++;
    end
    while (!wb_rsp.ack && n < 6);
    rdat = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
  endtask

  task automatic reg_write(input int ch, input int rg, input ttc_pkg::wb_dat_t dat);
    ttc_pkg::wb_dat_t rsp_dat;
    model_write(ch, rg, dat);
    exp_en = 1'b0;
    bus_xfer(1'b1, reg_adr(ch, rg), dat, rsp_dat);
  endtask

  task automatic reg_read(input int ch, input int rg, input ttc_pkg::wb_dat_t lo,
                          input ttc_pkg::wb_dat_t hi, input logic chk,
                          output ttc_pkg::wb_dat_t data);
    exp_en = chk;
    exp_lo = lo;
    exp_hi = hi;
    bus_xfer(1'b0, reg_adr(ch, rg), '0, data);
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge pclk10);
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial
  begin
    ttc_pkg::wb_dat_t rd;
    ttc_pkg::wb_dat_t rd2;
    ttc_pkg::wb_dat_t lo;
    int ch;
    int rg;
    int iv;
    int ex;
    int ps_on;
    int per;
    int d;
    int w;
    seed = 32'h66ca;
    wb_req = '0;
    n_p_reset10 = 1'b0;
    exp_en = 1'b0;
    exp_lo = '0;
    exp_hi = '0;
    irq_chk_en = 1'b0;
    irq_exp = 1'b0;
    m_en = '0;
    for (int c = 0; c < `TTC_NUM_CH; c++)
    begin
      m_clk[c] = '0;
      m_ctrl[c] = '0;
      m_iv[c] = '0;
    end
    repeat (16) @(posedge pclk10);
    @(negedge pclk10);
    n_p_reset10 = 1'b1;

    // everything but the running counters reads 0 after reset
    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++)
        if (c == SHARED || r != 3)
          reg_read(c, r, '0, '0, 1'b1, rd);

    // random readback, shared reg 0 skipped since reading clears it
    for (int i = 0; i < N_RAND; i++)
    begin
      ch = pick(0, SHARED);
      rg = (ch == SHARED) ? pick(1, 3) : pick(0, 2);
      reg_write(ch, rg, $random(seed));
      reg_read(ch, rg, model_read(ch, rg), model_read(ch, rg), 1'b1, rd);
    end

    // disable freezes the count, restart while disabled zeroes it
    for (int i = 0; i < 3; i++)
    begin
      ch = pick(0, `TTC_NUM_CH - 1);
      reg_write(ch, 0, 0);
      reg_write(ch, 1, 0);
      idle(pick(5, 40));
      reg_write(ch, 1, 1);
      reg_read(ch, 3, '0, '0, 1'b0, rd);
      idle(pick(20, 60));
      reg_read(ch, 3, rd, rd, 1'b1, rd2);
      reg_write(ch, 1, 5);
      reg_read(ch, 3, '0, '0, 1'b1, rd);
    end

    // interval mode bound, exact progress with the prescaler off
    for (int i = 0; i < 8; i++)
    begin
      ch = pick(0, `TTC_NUM_CH - 1);
      iv = pick(4, 40);
      ex = pick(0, 2);
      ps_on = pick(0, 1);
      reg_write(ch, 1, 5);
      reg_write(ch, 2, iv);
      reg_write(ch, 0, (ex << 1) | ps_on);
      reg_write(ch, 1, 2);
      w = pick(1, 30);
      idle(w);
      // count sits at 0 through the enable edge, first read sees w+1 ticks
      lo = ttc_pkg::wb_dat_t'((w + 1) % (iv + 1));
      if (ps_on != 0)
        reg_read(ch, 3, '0, iv, 1'b1, rd);
      else
        reg_read(ch, 3, lo, lo, 1'b1, rd);
      d = pick(0, iv - 3);
      idle(d);
      // sampling edges of the two reads are d+2 apart
      lo = ttc_pkg::wb_dat_t'((w + 1 + d + 2) % (iv + 1));
      if (ps_on != 0)
        reg_read(ch, 3, '0, iv, 1'b1, rd2);
      else
        reg_read(ch, 3, lo, lo, 1'b1, rd2);
    end

    // status set after one full interval, irq through the mask, clear on read
    for (int i = 0; i < 4; i++)
    begin
      for (int c = 0; c < `TTC_NUM_CH; c++)
        reg_write(c, 1, 1);
      reg_read(SHARED, 0, '0, '0, 1'b0, rd);
      ch = pick(0, `TTC_NUM_CH - 1);
      iv = pick(4, 40);
      ex = pick(0, 2);
      ps_on = pick(0, 1);
      per = (ps_on != 0) ? (2 << ex) : 1;
      reg_write(SHARED, 1, pick(0, 7));
      reg_write(ch, 2, iv);
      reg_write(ch, 0, (ex << 1) | ps_on);
      reg_write(ch, 1, 6);
      idle((iv + 1) * per + 4);
      // stop before the second wrap
      reg_write(ch, 1, 3);
      irq_exp = m_en[ch];
      irq_chk_en = 1'b1;
      idle(4);
      irq_chk_en = 1'b0;
      reg_read(SHARED, 0, 1 << ch, 1 << ch, 1'b1, rd);
      reg_read(SHARED, 0, '0, '0, 1'b1, rd);
      irq_exp = 1'b0;
      irq_chk_en = 1'b1;
      idle(3);
      irq_chk_en = 1'b0;
    end

    // restart on a running channel, read two edges after the restart write
    for (int i = 0; i < 4; i++)
    begin
      ch = pick(0, `TTC_NUM_CH - 1);
      reg_write(ch, 2, 40);
      reg_write(ch, 0, 0);
      reg_write(ch, 1, 2);
      idle(pick(5, 30));
      reg_write(ch, 1, 6);
      // restart edge and the dead count_en cycle leave no tick
      reg_read(ch, 3, '0, '0, 1'b1, rd);
    end

    idle(4);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog against a hung bus or stimulus loop
  initial
  begin
    #(WD_NS);
    $display("timeout: the run did not finish within the watchdog limit");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* project.f */
+incdir+.
ttc_pkg.sv
ttc_count_rst.sv
ttc_channel.sv
ttc_wb_regs.sv
ttc_irq_combine.sv
ttc_top.sv
tb_ttc_checker.sv
tb_ttc.sv

/* Bender.yml */
package:
  name: ttc

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ttc_pkg.sv
      - ttc_count_rst.sv
      - ttc_channel.sv
      - ttc_wb_regs.sv
      - ttc_irq_combine.sv
      - ttc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ttc_checker.sv
      - tb_ttc.sv
